/* flist.f */
design/regFilePkg.sv
design/regFile1r1w.sv
design/regFileTestWrap.sv
design/marchBist.sv
design/regFileBistTop.sv
verification/regFileBistTb.sv

/* run.sh */
#!/bin/sh
# Builds the register file self-test simulation with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --timescale 1ns/100ps \
   --top-module regFileBistTb \
   -f flist.f \
   -o simRegFileBist

# The simulator's exit status is not used, the log decides
./obj_dir/simRegFileBist > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "Simulation failed"
   exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
   echo "Simulation ended without a result"
   exit 1
fi

echo "Simulation passed"

/* verification/regFileBistTb.sv */
// Directed testbench for the register file with March C- self-test
// Checks functional reads and writes, self-test timing, final contents and back-to-back runs
module regFileBistTb
   import regFilePkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int numWords = 32;
   localparam int clkPeriod = 100;
   localparam int driveDelay = 10;

   // One self-test run lasts 10 passes over the array plus the final compare cycle
   localparam int bistCycles = 10 * numWords + 1;

   // Reset, functional tests, three runs with a readback each, plus a margin
   localparam int testCycles = 4 + 2 * numWords + 6 + 3 * (bistCycles + 4) + 3 * numWords;
   localparam int watchdogCycles = testCycles + 200;

   logic    clk = 1'b0;
   logic    rstN;
   logic    readEnable;
   regAddrT readAddr;
   regDataT readData;
   logic    writeEnable;
   regAddrT writeAddr;
   regDataT writeData;
   logic    bistStart;
   regDataT bistBackground;
   logic    bistBusy;
   logic    bistDone;
   logic    bistFail;

   // Expected contents of the array
   regDataT model [numWords];

   // State of the pseudo random generator
   regDataT lcgState = 32'd77;

   regFileBistTop #(
      .numWords       (numWords)
   ) regFileBistTop_inst (
      .clk            (clk),
      .rstN           (rstN),
      .readEnable     (readEnable),
      .readAddr       (readAddr),
      .readData       (readData),
      .writeEnable    (writeEnable),
      .writeAddr      (writeAddr),
      .writeData      (writeData),
      .bistStart      (bistStart),
      .bistBackground (bistBackground),
      .bistBusy       (bistBusy),
      .bistDone       (bistDone),
      .bistFail       (bistFail)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Linear congruential generator that returns one new word per call
   function automatic regDataT nextRandom();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Advance to the point after the edge where outputs are sampled and inputs change
   task automatic nextCycle();
      @(posedge clk);
      #(driveDelay);
   endtask

   task automatic checkData(input string testName, input regDataT expected, input regDataT actual);
      if (actual !== expected)
      begin
         $display("Error in %s: expected %h, actual %h", testName, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "Data mismatch");
      end
   endtask

   task automatic checkFlag(input string testName, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("Error in %s: expected %b, actual %b", testName, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "Flag mismatch");
      end
   endtask

   task automatic checkCount(input string testName, input int expected, input int actual);
      if (actual != expected)
      begin
         $display("Error in %s: expected %0d, actual %0d", testName, expected, actual);
         $display("RESULT: FAIL");
         $fatal(1, "Cycle count mismatch");
      end
   endtask

   task automatic writeWord(input regAddrT addr, input regDataT data);
      writeEnable = 1'b1;
      writeAddr   = addr;
      writeData   = data;
      nextCycle();
      writeEnable = 1'b0;
      model[addr] = data;
   endtask

   // Read data is registered, so it is checked one cycle after the strobe
   task automatic readCheck(input string testName, input regAddrT addr);
      readEnable = 1'b1;
      readAddr   = addr;
      nextCycle();
      readEnable = 1'b0;
      checkData(testName, model[addr], readData);
   endtask

   task automatic readAll(input string testName);
      for (int i = 0; i < numWords; i++)
      begin
         readCheck(testName, regAddrT'(i));
      end
   endtask

   // Starts a run, counts busy cycles and checks the done pulse and fail flag
   // With scribble set, functional writes of other data are driven on every busy cycle
   task automatic runBist(input string testName, input regDataT background, input bit scribble);
      int busyCycles;
      busyCycles = 0;
      bistBackground = background;
      bistStart = 1'b1;
      nextCycle();
      bistStart = 1'b0;
      while (bistBusy)
      begin
         busyCycles++;
         if (scribble)
         begin
            writeEnable = 1'b1;
            writeAddr   = regAddrT'(nextRandom() % numWords);
            writeData   = ~background;
         end
         nextCycle();
      end
      writeEnable = 1'b0;
      checkCount({testName, " busy cycles"}, bistCycles, busyCycles);
      checkFlag({testName, " done pulse"}, 1'b1, bistDone);
      checkFlag({testName, " fail flag"}, 1'b0, bistFail);
      nextCycle();
      checkFlag({testName, " done low"}, 1'b0, bistDone);
      checkFlag({testName, " fail sticky"}, 1'b0, bistFail);
      // A clean run leaves the background in every word
      for (int i = 0; i < numWords; i++)
      begin
         model[i] = background;
      end
   endtask

   task automatic testWriteReadBack();
      for (int i = 0; i < numWords; i++)
      begin
         writeWord(regAddrT'(i), nextRandom());
      end
      readAll("write read back");
   endtask

   // The read in the write cycle sees the old word and the next read sees the new one
   task automatic testSameCycle();
      regAddrT addr;
      regDataT oldWord;
      regDataT newWord;
      addr    = regAddrT'(numWords / 2);
      oldWord = model[addr];
      newWord = ~nextRandom();
      readEnable  = 1'b1;
      readAddr    = addr;
      writeEnable = 1'b1;
      writeAddr   = addr;
      writeData   = newWord;
      nextCycle();
      readEnable  = 1'b0;
      writeEnable = 1'b0;
      checkData("same cycle old word", oldWord, readData);
      model[addr] = newWord;
      readCheck("same cycle new word", addr);
   endtask

   task automatic testBistTiming(input regDataT background);
      runBist("bist timing", background, 1'b0);
   endtask

   task automatic testBistContents();
      readAll("bist contents");
   endtask

   task automatic testIgnoreWrites(input regDataT background);
      runBist("bist ignores writes", background, 1'b1);
      readAll("bist ignores writes contents");
   endtask

   // Read data still holds the background after the readback
   // A fresh word at address 0 shows the functional port owns the array again
   task automatic testBackToBack(input regDataT background);
      runBist("back to back", ~background, 1'b0);
      readAll("back to back contents");
      writeWord(regAddrT'(0), nextRandom());
      readCheck("functional access after test", regAddrT'(0));
   endtask

   // Ends a run that stops making progress
   initial
   begin
      #(watchdogCycles * clkPeriod);
      $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
      $display("RESULT: FAIL");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      regDataT background;
      rstN           = 1'b0;
      readEnable     = 1'b0;
      readAddr       = '0;
      writeEnable    = 1'b0;
      writeAddr      = '0;
      writeData      = '0;
      bistStart      = 1'b0;
      bistBackground = '0;
      repeat (4) @(posedge clk);
      #(driveDelay);
      rstN = 1'b1;
      checkFlag("reset busy", 1'b0, bistBusy);
      checkFlag("reset done", 1'b0, bistDone);
      checkFlag("reset fail", 1'b0, bistFail);
      checkData("reset read data", '0, readData);

      testWriteReadBack();
      testSameCycle();
      background = nextRandom();
      testBistTiming(background);
      testBistContents();
      background = nextRandom();
      testIgnoreWrites(background);
      testBackToBack(background);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* design/regFileBistTop.sv */
// Register file macro with built-in March C- self-test
// Connects the self-test sequencer to the test port of the wrapped register file
module regFileBistTop
   import regFilePkg::*;
#(
   parameter int numWords = 32
)
(
   input  logic    clk,
   input  logic    rstN,

   // Functional read port, data one cycle after the strobe
   input  logic    readEnable,
   input  regAddrT readAddr,
   output regDataT readData,

   // Functional write port
   input  logic    writeEnable,
   input  regAddrT writeAddr,
   input  regDataT writeData,

   // Self-test control and status
   input  logic    bistStart,
   input  regDataT bistBackground,
   output logic    bistBusy,
   output logic    bistDone,
   output logic    bistFail
);

   // Links between the sequencer and the wrapper
   logic    bistMode;
   memPortT testPort;
   regDataT testData;

   marchBist #(
      .numWords       (numWords)
   ) marchBist_inst (
      .clk            (clk),
      .rstN           (rstN),
      .bistStart      (bistStart),
      .bistBackground (bistBackground),
      .bistMode       (bistMode),
      .testPort       (testPort),
      .testData       (testData),
      .bistBusy       (bistBusy),
      .bistDone       (bistDone),
      .bistFail       (bistFail)
   );

   // Functional ports pass through the wrapper, which hands the array to the test port
   regFileTestWrap #(
      .numWords    (numWords)
   ) regFileTestWrap_inst (
      .clk         (clk),
      .rstN        (rstN),
      .bistMode    (bistMode),
      .testPort    (testPort),
      .testData    (testData),
      .readEnable  (readEnable),
      .readAddr    (readAddr),
      .readData    (readData),
      .writeEnable (writeEnable),
      .writeAddr   (writeAddr),
      .writeData   (writeData)
   );

endmodule

/* design/marchBist.sv */
// March C- memory self-test sequencer
// Drives the memory test port, checks each read one cycle later and reports done and fail
module marchBist
   import regFilePkg::*;
#(
   parameter int numWords = 32
)
(
   input  logic    clk,
   input  logic    rstN,

   // Run control and data background
   input  logic    bistStart,
   input  regDataT bistBackground,

   // Memory test port
   output logic    bistMode,
   output memPortT testPort,
   input  regDataT testData,

   // Status
   output logic    bistBusy,
   output logic    bistDone,
   output logic    bistFail
);

   // Operation issued on the test port in the current cycle
   typedef enum logic [1:0]
   {
      opNone,
      opRead,
      opWrite
   } marchOpT;

   // Highest populated address, where up elements end and down elements begin
   localparam regAddrT lastAddr = regAddrT'(numWords - 1);

   // Sequencer state
   marchStateT state;
   marchStateT stateAfter;
   regAddrT    addr;
   regAddrT    addrAfter;
   logic       phase;

   // Background captured at start, and the word the pending read should return
   regDataT    bgReg;
   regDataT    expected;
   logic       cmpValid;

   // Decoded element properties
   logic       twoOp;
   logic       isDown;
   logic       opLast;
   logic       elemEnd;
   logic       startRun;
   logic       mismatch;
   marchOpT    marchOp;
   regDataT    readPattern;

   assign startRun = (state == idle) && bistStart;

   // Elements m1 to m4 do a read then a write per address, phase picks which
   // M0 and M5 do one operation per address
   always_comb
   begin
      twoOp   = state inside {m1Up, m2Up, m3Down, m4Down};
      isDown  = state inside {m3Down, m4Down, m5Down};
      opLast  = !twoOp || phase;
      elemEnd = opLast && (addr == (isDown ? regAddrT'(0) : lastAddr));
   end

   // Operation for this cycle
   always_comb
   begin
      if (twoOp)
      begin
         marchOp = phase ? opWrite : opRead;
      end
      else if (state == m0Write)
      begin
         marchOp = opWrite;
      end
      else if (state == m5Down)
      begin
         marchOp = opRead;
      end
      else
      begin
         marchOp = opNone;
      end
   end

   // M2 and M4 read the inverted background, the others read it plain
   // Every read-write element writes the inverse of what it just read
   assign readPattern = (state inside {m2Up, m4Down}) ? ~bgReg : bgReg;

   always_comb
   begin
      testPort.csn   = (marchOp == opNone);
      testPort.wen   = (marchOp != opWrite);
      testPort.addr  = addr;
      testPort.wdata = (state == m0Write) ? bgReg : ~readPattern;
   end

   // Next element and the address it starts from
   always_comb
   begin
      case (state)
         m0Write: stateAfter = m1Up;
         m1Up:    stateAfter = m2Up;
         m2Up:    stateAfter = m3Down;
         m3Down:  stateAfter = m4Down;
         m4Down:  stateAfter = m5Down;
         m5Down:  stateAfter = finish;
         default: stateAfter = idle;
      endcase
      // Up elements start at zero, down elements at the top
      addrAfter = (stateAfter inside {m3Down, m4Down, m5Down}) ? lastAddr : '0;
   end

   // State, address and phase
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state <= idle;
         addr  <= '0;
         phase <= 1'b0;
      end
      else
      begin
         case (state)
            idle:
            begin
               if (bistStart)
               begin
                  state <= m0Write;
                  addr  <= '0;
                  phase <= 1'b0;
               end
            end
            // One spare cycle to check the last read of M5
            finish:
            begin
               state <= idle;
            end
            default:
            begin
               if (elemEnd)
               begin
                  state <= stateAfter;
                  addr  <= addrAfter;
                  phase <= 1'b0;
               end
               else
               begin
                  phase <= twoOp && !phase;
                  if (opLast)
                  begin
                     addr <= isDown ? addr - 1'b1 : addr + 1'b1;
                  end
               end
            end
         endcase
      end
   end

   // Payload registers
   always_ff @(posedge clk)
   begin
      if (startRun)
      begin
         bgReg <= bistBackground;
      end
      if (marchOp == opRead)
      begin
         expected <= readPattern;
      end
   end

   // Read data arrives one cycle after the read strobe
   assign mismatch = cmpValid && (testData != expected);

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         cmpValid <= 1'b0;
         bistDone <= 1'b0;
         bistFail <= 1'b0;
      end
      else
      begin
         cmpValid <= (marchOp == opRead);
         bistDone <= (state == finish);
         // Fail is sticky for the whole run and only a new start clears it
         if (startRun)
         begin
            bistFail <= 1'b0;
         end
         else if (mismatch)
         begin
            bistFail <= 1'b1;
         end
      end
   end

   // Test mode follows busy, so the wrapper owns the array for the whole run
   assign bistBusy = (state != idle);
   assign bistMode = bistBusy;

   // A start during a run would be lost, the driver must wait for done
   startWhileIdle: assert property (
      @(posedge clk) disable iff (!rstN)
      bistStart |-> !bistBusy
   );

   // Done comes exactly once, in the cycle right after busy drops
   doneAfterBusy: assert property (
      @(posedge clk) disable iff (!rstN)
      bistDone |-> !bistBusy && $past(bistBusy)
   );

endmodule

/* design/regFileTestWrap.sv */
// Test wrapper around the register file
// Muxes the active-low test port over the functional ports while in test mode
module regFileTestWrap
   import regFilePkg::*;
#(
   parameter int numWords = 32
)
(
   input  logic    clk,
   input  logic    rstN,

   // Test mode select and test port
   input  logic    bistMode,
   input  memPortT testPort,
   output regDataT testData,

   // Functional read port
   input  logic    readEnable,
   input  regAddrT readAddr,
   output regDataT readData,

   // Functional write port
   input  logic    writeEnable,
   input  regAddrT writeAddr,
   input  regDataT writeData
);

   // Port signals after the mode mux
   logic    readEnableMux;
   regAddrT readAddrMux;
   logic    writeEnableMux;
   regAddrT writeAddrMux;
   regDataT writeDataMux;

   // Read data straight from the array
   regDataT arrayData;

   // In test mode the functional strobes are dropped
   // The shared test address drives both the read and the write side
   always_comb
   begin
      if (bistMode)
      begin
         readEnableMux  = !testPort.csn && testPort.wen;
         readAddrMux    = testPort.addr;
         writeEnableMux = !testPort.csn && !testPort.wen;
         writeAddrMux   = testPort.addr;
         writeDataMux   = testPort.wdata;
      end
      else
      begin
         readEnableMux  = readEnable;
         readAddrMux    = readAddr;
         writeEnableMux = writeEnable;
         writeAddrMux   = writeAddr;
         writeDataMux   = writeData;
      end
   end

   // Both outputs see the same registered read data
   assign readData = arrayData;
   assign testData = arrayData;

   regFile1r1w #(
      .numWords    (numWords)
   ) regFile1r1w_inst (
      .clk         (clk),
      .rstN        (rstN),
      .readEnable  (readEnableMux),
      .readAddr    (readAddrMux),
      .readData    (arrayData),
      .writeEnable (writeEnableMux),
      .writeAddr   (writeAddrMux),
      .writeData   (writeDataMux)
   );

   // The sequencer must hold test mode for as long as it touches the test port
   testAccessInMode: assert property (
      @(posedge clk) disable iff (!rstN)
      !testPort.csn |-> bistMode
   );

endmodule

/* design/regFile1r1w.sv */
// Flop based register file with one registered read port and one write port
// Writes land on the strobe edge, read data is valid one cycle after the read strobe
module regFile1r1w
   import regFilePkg::*;
#(
   parameter int numWords = 32
)
(
   input  logic    clk,
   input  logic    rstN,

   // Read port
   input  logic    readEnable,
   input  regAddrT readAddr,
   output regDataT readData,

   // Write port
   input  logic    writeEnable,
   input  regAddrT writeAddr,
   input  regDataT writeData
);

   // Storage array, contents are undefined until written
   regDataT regArray [numWords];

   // The depth must fit in the address space of the package
   if (numWords > (1 << addrWidth))
   begin : gDepthCheck
      $error("regFile1r1w depth exceeds the address space");
   end

   // Synchronous write, one word per cycle
   always_ff @(posedge clk)
   begin
      if (writeEnable)
      begin
         regArray[writeAddr] <= writeData;
      end
   end

   // Registered read
   // A write to the same address in this cycle is not yet visible, so the old word returns
   // Without a strobe the last read word is held
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         readData <= '0;
      end
      else if (readEnable)
      begin
         readData <= regArray[readAddr];
      end
   end

   // Callers must keep enabled addresses inside the populated depth
   // This matters when numWords is smaller than the full address space
   readAddrInRange: assert property (
      @(posedge clk) disable iff (!rstN)
      readEnable |-> (int'(readAddr) < numWords)
   );

   writeAddrInRange: assert property (
      @(posedge clk) disable iff (!rstN)
      writeEnable |-> (int'(writeAddr) < numWords)
   );

endmodule

/* design/regFilePkg.sv */
// Register file BIST package
// Shared widths, word and address types, the memory test port and the March C- states
package regFilePkg;

   // Array address width, which also sizes the test port struct
   localparam int addrWidth = 5;

   // Width of one register word
   localparam int dataWidth = 32;

   // One array address
   typedef logic [addrWidth-1:0] regAddrT;

   // One register word
   typedef logic [dataWidth-1:0] regDataT;

   // Memory macro style test port, all controls active low
   // A read is csn low with wen high, a write is csn low with wen low
   // The struct packs to 39 bits with the default widths
   typedef struct packed
   {
      // Chip select, high means the port is idle
      logic    csn;
      // Write enable, only looked at while csn is low
      logic    wen;
      // Word address for both reads and writes
      regAddrT addr;
      // Write data, ignored on reads
      regDataT wdata;
   } memPortT;

   // March C- sequencer states, in the order they are visited
   // Each mN state covers one march element over the whole array
   typedef enum logic [2:0]
   {
      idle,
      m0Write,
      m1Up,
      m2Up,
      m3Down,
      m4Down,
      m5Down,
      finish
   } marchStateT;

endpackage
